// File: compile.f
+incdir+design
design/adder_pkg.sv
design/adder_exe_if.sv
design/adder_buffer.sv
design/adder_issue.sv
design/adder_execute.sv
design/adder_regfile.sv
design/adder_lane.sv
verification/adder_asserts.sv
verification/adder_tb.sv

// File: design/adder_buffer.sv
`timescale 1ns/10ps
`include "adder_params.svh"

module adder_buffer (
	input  logic                             CLK,
	input  logic                             reset,
	input  logic                             flush,
	input  logic                             dispatch,
	input  adder_pkg::adder_issue_info_s     dispatch_info,
	input  logic                             pop,
	input  logic [$clog2(`ADDER_DP)-1:0]     pop_index,
	output logic [`ADDER_DP-1:0]             malloc,
	output adder_pkg::adder_issue_info_s     info [`ADDER_DP],
	output logic                             full
);

	import adder_pkg::*;

	localparam int IW = $clog2(`ADDER_DP);

	logic [IW-1:0] free_index;
	logic          accept;

	// lowest empty slot
	always_comb begin
		free_index = '0;
		for (int i = `ADDER_DP - 1; i >= 0; i--) begin
			if (!malloc[i]) begin
				free_index = IW'(i);
			end
		end
	end

	assign full = &malloc;

	// sender honours full, the check only guards the array
	assign accept = dispatch & ~full & ~flush;

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			malloc <= '0;
		end else begin
			// pop and dispatch never name the same slot
			if (pop) begin
				malloc[pop_index] <= 1'b0;
			end
			if (accept) begin
				malloc[free_index] <= 1'b1;
			end
		end
	end

	// payload only, valid bits say what is live
	always_ff @(posedge CLK) begin
		if (accept) begin
			info[free_index] <= dispatch_info;
		end
	end

endmodule

// File: design/adder_exe_if.sv
`timescale 1ns/10ps
`include "adder_params.svh"

interface adder_exe_if;

	logic                           valid;
	logic                           fun_sub;
	logic                           is32;
	logic [$clog2(`ADDER_NREG)-1:0] rd;
	logic [`ADDER_XLEN-1:0]         op1;
	logic [`ADDER_XLEN-1:0]         op2;

	// issue register drives, adder consumes
	modport issue (output valid, fun_sub, is32, rd, op1, op2);
	modport execute (input valid, fun_sub, is32, rd, op1, op2);

endinterface

// File: design/adder_execute.sv
`timescale 1ns/10ps
`include "adder_params.svh"

module adder_execute (
	input  logic                           CLK,
	input  logic                           reset,
	adder_exe_if.execute                   exe,
	output logic                           wb_valid,
	output logic [$clog2(`ADDER_NREG)-1:0] wb_rd,
	output logic [`ADDER_XLEN-1:0]         wb_data
);

	logic [`ADDER_XLEN-1:0] sum;
	logic [`ADDER_XLEN-1:0] result;

	assign sum = exe.fun_sub ? exe.op1 - exe.op2 : exe.op1 + exe.op2;

	// word forms keep the low half, sign-extended
	assign result = exe.is32 ? {{(`ADDER_XLEN - 32){sum[31]}}, sum[31:0]} : sum;

	always_ff @(posedge CLK) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe.valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exe.valid) begin
			wb_rd   <= exe.rd;
			wb_data <= result;
		end
	end

endmodule

// File: design/adder_issue.sv
`timescale 1ns/10ps
`include "adder_params.svh"

module adder_issue (
	input  logic                               CLK,
	input  logic                               reset,
	input  logic                               flush,
	input  logic [`ADDER_DP-1:0]               malloc,
	input  adder_pkg::adder_issue_info_s       info [`ADDER_DP],
	input  logic [`ADDER_NREG-1:0]             wb_log,
	output logic [$clog2(`ADDER_NREG)-1:0]     rs1_addr [`ADDER_DP],
	output logic [$clog2(`ADDER_NREG)-1:0]     rs2_addr [`ADDER_DP],
	input  logic [`ADDER_XLEN-1:0]             rs1_data [`ADDER_DP],
	input  logic [`ADDER_XLEN-1:0]             rs2_data [`ADDER_DP],
	output logic                               pop,
	output logic [$clog2(`ADDER_DP)-1:0]       pop_index,
	adder_exe_if.issue                         exe
);

	import adder_pkg::*;

	localparam int IW = $clog2(`ADDER_DP);

	logic [`ADDER_DP-1:0]   ready;
	logic [`ADDER_DP-1:0]   is_sub;
	logic [`ADDER_DP-1:0]   is_w;
	logic [`ADDER_XLEN-1:0] op1 [`ADDER_DP];
	logic [`ADDER_XLEN-1:0] op2 [`ADDER_DP];
	logic                   any_ready;

	for (genvar i = 0; i < `ADDER_DP; i++) begin : g_entry
		logic                   rs1_ok;
		logic                   rs2_ok;
		logic                   src_ok;
		logic [`ADDER_XLEN-1:0] opa;
		logic [`ADDER_XLEN-1:0] opb;

		assign rs1_addr[i] = info[i].rs1;
		assign rs2_addr[i] = info[i].rs2;

		// x0 always shows as written in wb_log
		assign rs1_ok = wb_log[info[i].rs1];
		assign rs2_ok = wb_log[info[i].rs2];

		always_comb begin
			src_ok = rs1_ok & rs2_ok;
			opa    = rs1_data[i];
			opb    = rs2_data[i];
			case (info[i].op)
				OP_LUI: begin
					src_ok = 1'b1;
					opa    = '0;
					opb    = info[i].imm;
				end
				OP_AUIPC: begin
					src_ok = 1'b1;
					opa    = info[i].pc;
					opb    = info[i].imm;
				end
				OP_ADDI, OP_ADDIW: begin
					src_ok = rs1_ok;
					opb    = info[i].imm;
				end
				default: ;
			endcase
		end

		assign ready[i]  = malloc[i] & src_ok;
		assign op1[i]    = opa;
		assign op2[i]    = opb;
		assign is_sub[i] = info[i].op inside {OP_SUB, OP_SUBW};
		assign is_w[i]   = info[i].op inside {OP_ADDIW, OP_ADDW, OP_SUBW};
	end

	// lowest ready entry wins
	always_comb begin
		pop_index = '0;
		any_ready = 1'b0;
		for (int i = `ADDER_DP - 1; i >= 0; i--) begin
			if (ready[i]) begin
				pop_index = IW'(i);
				any_ready = 1'b1;
			end
		end
	end

	assign pop = any_ready & ~flush;

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			exe.valid <= 1'b0;
		end else begin
			exe.valid <= pop;
		end
	end

	// execute parameters, cancelled on flush
	always_ff @(posedge CLK) begin
		if (flush) begin
			exe.fun_sub <= 1'b0;
			exe.is32    <= 1'b0;
			exe.rd      <= '0;
			exe.op1     <= '0;
			exe.op2     <= '0;
		end else if (pop) begin
			exe.fun_sub <= is_sub[pop_index];
			exe.is32    <= is_w[pop_index];
			exe.rd      <= info[pop_index].rd;
			exe.op1     <= op1[pop_index];
			exe.op2     <= op2[pop_index];
		end
	end

endmodule

// File: design/adder_lane.sv
`timescale 1ns/10ps
`include "adder_params.svh"

module adder_lane (
	input  logic                           CLK,
	input  logic                           reset,
	input  logic                           flush,
	input  logic                           dispatch,
	input  adder_pkg::adder_op_e           dispatch_op,
	input  logic [`ADDER_XLEN-1:0]         dispatch_pc,
	input  logic [`ADDER_XLEN-1:0]         dispatch_imm,
	input  logic [$clog2(`ADDER_NREG)-1:0] dispatch_rd,
	input  logic [$clog2(`ADDER_NREG)-1:0] dispatch_rs1,
	input  logic [$clog2(`ADDER_NREG)-1:0] dispatch_rs2,
	output logic                           full,
	output logic                           wb_valid,
	output logic [$clog2(`ADDER_NREG)-1:0] wb_rd,
	output logic [`ADDER_XLEN-1:0]         wb_data
);

	import adder_pkg::*;

	adder_issue_info_s              dispatch_info;
	adder_issue_info_s              info [`ADDER_DP];
	logic [`ADDER_DP-1:0]           malloc;
	logic                           pop;
	logic [$clog2(`ADDER_DP)-1:0]   pop_index;
	logic [`ADDER_NREG-1:0]         wb_log;
	logic [$clog2(`ADDER_NREG)-1:0] rs1_addr [`ADDER_DP];
	logic [$clog2(`ADDER_NREG)-1:0] rs2_addr [`ADDER_DP];
	logic [`ADDER_XLEN-1:0]         rs1_data [`ADDER_DP];
	logic [`ADDER_XLEN-1:0]         rs2_data [`ADDER_DP];

	adder_exe_if exe_bus ();

	// pack the incoming fields into one buffer entry
	assign dispatch_info = '{
		op:  dispatch_op,
		pc:  dispatch_pc,
		imm: dispatch_imm,
		rd:  dispatch_rd,
		rs1: dispatch_rs1,
		rs2: dispatch_rs2
	};

	adder_buffer i_buffer (
		.CLK(CLK), .reset(reset), .flush(flush),
		.dispatch(dispatch), .dispatch_info(dispatch_info),
		.pop(pop), .pop_index(pop_index),
		.malloc(malloc), .info(info), .full(full)
	);

	adder_issue i_issue (
		.CLK(CLK), .reset(reset), .flush(flush),
		.malloc(malloc), .info(info), .wb_log(wb_log),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.pop(pop), .pop_index(pop_index),
		.exe(exe_bus.issue)
	);

	adder_execute i_execute (
		.CLK(CLK), .reset(reset),
		.exe(exe_bus.execute),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	adder_regfile i_regfile (
		.CLK(CLK), .reset(reset), .flush(flush),
		.dispatch(dispatch), .dispatch_rd(dispatch_rd),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.wb_log(wb_log)
	);

endmodule

// File: design/adder_params.svh
`ifndef ADDER_PARAMS_SVH
`define ADDER_PARAMS_SVH

// issue buffer entries
`define ADDER_DP 4

// integer data width
`define ADDER_XLEN 64

// architectural integer registers
`define ADDER_NREG 32

`endif

// File: design/adder_pkg.sv
`include "adder_params.svh"

package adder_pkg;

	// add-class operations accepted by the lane
	typedef enum logic [2:0] {
		OP_LUI   = 3'd0,
		OP_AUIPC = 3'd1,
		OP_ADDI  = 3'd2,
		OP_ADDIW = 3'd3,
		OP_ADD   = 3'd4,
		OP_ADDW  = 3'd5,
		OP_SUB   = 3'd6,
		OP_SUBW  = 3'd7
	} adder_op_e;

	// one buffered instruction, imm already sign-extended
	typedef struct packed {
		adder_op_e                      op;
		logic [`ADDER_XLEN-1:0]         pc;
		logic [`ADDER_XLEN-1:0]         imm;
		logic [$clog2(`ADDER_NREG)-1:0] rd;
		logic [$clog2(`ADDER_NREG)-1:0] rs1;
		logic [$clog2(`ADDER_NREG)-1:0] rs2;
	} adder_issue_info_s;

endpackage

// File: design/adder_regfile.sv
`timescale 1ns/10ps
`include "adder_params.svh"

module adder_regfile (
	input  logic                           CLK,
	input  logic                           reset,
	input  logic                           flush,
	input  logic                           dispatch,
	input  logic [$clog2(`ADDER_NREG)-1:0] dispatch_rd,
	input  logic [$clog2(`ADDER_NREG)-1:0] rs1_addr [`ADDER_DP],
	input  logic [$clog2(`ADDER_NREG)-1:0] rs2_addr [`ADDER_DP],
	output logic [`ADDER_XLEN-1:0]         rs1_data [`ADDER_DP],
	output logic [`ADDER_XLEN-1:0]         rs2_data [`ADDER_DP],
	input  logic                           wb_valid,
	input  logic [$clog2(`ADDER_NREG)-1:0] wb_rd,
	input  logic [`ADDER_XLEN-1:0]         wb_data,
	output logic [`ADDER_NREG-1:0]         wb_log
);

	logic [`ADDER_XLEN-1:0] regs [`ADDER_NREG];
	logic [`ADDER_NREG-1:0] written;

	// x0 is never written, so it keeps its reset zero
	always_ff @(posedge CLK) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (wb_valid && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// no pending producer survives a flush
	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			written <= '1;
		end else begin
			if (wb_valid) begin
				written[wb_rd] <= 1'b1;
			end
			// a new producer of rd takes priority
			if (dispatch) begin
				written[dispatch_rd] <= 1'b0;
			end
		end
	end

	assign wb_log = written | `ADDER_NREG'(1);

	// one read pair per buffer entry
	for (genvar i = 0; i < `ADDER_DP; i++) begin : g_read
		assign rs1_data[i] = regs[rs1_addr[i]];
		assign rs2_data[i] = regs[rs2_addr[i]];
	end

endmodule

// File: verification/adder_asserts.sv
`timescale 1ns/10ps

module adder_asserts (
	input logic CLK,
	input logic reset,
	input logic flush,
	input logic pop,
	input logic exe_valid,
	input logic wb_valid,
	input logic full
);

	int assert_fails = 0;

	// writeback is exactly one edge behind execute
	wb_follows_exe: assert property (@(posedge CLK) disable iff (reset)
		wb_valid == $past(exe_valid))
	else begin
		assert_fails++;
		$error("wb_valid does not follow exe valid by one cycle");
	end

	full_after_reset: assert property (@(posedge CLK) reset |=> !full)
	else begin
		assert_fails++;
		$error("full is high right after reset");
	end

	no_pop_in_flush: assert property (@(posedge CLK) disable iff (reset) flush |-> !pop)
	else begin
		assert_fails++;
		$error("pop raised while flush is high");
	end

endmodule

bind adder_lane adder_asserts i_asserts (
	.CLK(CLK), .reset(reset), .flush(flush), .pop(pop),
	.exe_valid(exe_bus.valid), .wb_valid(wb_valid), .full(full)
);

// File: verification/adder_tb.sv
`timescale 1ns/10ps
`include "adder_params.svh"

module adder_tb;

	import adder_pkg::*;

	localparam int XL = `ADDER_XLEN;
	localparam int RW = $clog2(`ADDER_NREG);
	localparam int N_BEFORE = 120;
	localparam int N_AFTER = 120;
	// 40 cycles per instruction plus slack for reset and flush
	localparam int WATCHDOG_CYCLES = (N_BEFORE + N_AFTER) * 40 + 100;

	logic          CLK;
	logic          reset;
	logic          flush;
	logic          dispatch;
	adder_op_e     dispatch_op;
	logic [XL-1:0] dispatch_pc;
	logic [XL-1:0] dispatch_imm;
	logic [RW-1:0] dispatch_rd;
	logic [RW-1:0] dispatch_rs1;
	logic [RW-1:0] dispatch_rs2;
	logic          full;
	logic          wb_valid;
	logic [RW-1:0] wb_rd;
	logic [XL-1:0] wb_data;

	// reference state, indexed by destination register
	logic [XL-1:0] committed [`ADDER_NREG];
	logic [XL-1:0] exp_val [`ADDER_NREG];
	logic [RW-1:0] pend_rs1 [`ADDER_NREG];
	logic [RW-1:0] pend_rs2 [`ADDER_NREG];
	bit            pend [`ADDER_NREG];
	int            use_cnt [`ADDER_NREG];
	int            n_pending = 0;
	int            n_sent = 0;
	int            n_checked = 0;
	int            n_flushed = 0;
	int            value_errors = 0;
	int            other_errors = 0;

	adder_lane i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic logic [XL-1:0] expected_result(adder_op_e op, logic [XL-1:0] pc,
			logic [XL-1:0] imm, logic [XL-1:0] a, logic [XL-1:0] b);
		logic [XL-1:0] sum;
		logic [31:0]   word;
		case (op)
			OP_LUI: sum = imm;
			OP_AUIPC: sum = pc + imm;
			OP_ADDI, OP_ADDIW: sum = a + imm;
			OP_ADD, OP_ADDW: sum = a + b;
			default: sum = a - b;
		endcase
		word = sum[31:0];
		if (op inside {OP_ADDIW, OP_ADDW, OP_SUBW}) begin
			return {{(XL - 32){word[31]}}, word};
		end
		return sum;
	endfunction

	// value a source sees in program order
	function automatic logic [XL-1:0] shadow_value(logic [RW-1:0] r);
		if (r == '0) begin
			return '0;
		end
		return pend[r] ? exp_val[r] : committed[r];
	endfunction

	task automatic send_batch(input int count);
		int            sent;
		adder_op_e     op;
		logic [RW-1:0] rd;
		logic [RW-1:0] rs1;
		logic [RW-1:0] rs2;
		logic [31:0]   u;
		logic [XL-1:0] imm;
		logic [XL-1:0] pc;
		sent = 0;
		while (sent < count) begin
			@(negedge CLK);
			dispatch = 1'b0;
			// a full buffer means at least that many instructions are outstanding
			assert (!full || n_pending >= `ADDER_DP) else begin
				$display("** Error at %0t: full high with only %0d instructions pending",
					$time, n_pending);
				value_errors++;
			end
			op = adder_op_e'($urandom_range(7));
			rd = RW'($urandom_range(7));
			rs1 = RW'($urandom_range(7));
			rs2 = RW'($urandom_range(7));
			u = $urandom;
			pc = {$urandom, $urandom} & ~64'h3;
			case (op)
				OP_LUI, OP_AUIPC: imm = {{32{u[31]}}, u[31:12], 12'h000};
				OP_ADDI, OP_ADDIW: imm = {{52{u[11]}}, u[11:0]};
				default: imm = {$urandom, u};
			endcase
			// no WAR or WAW against pending work, and no self dependence
			if (!full && $urandom_range(3) != 0 && use_cnt[rd] == 0 &&
					(rd == '0 || (rd != rs1 && rd != rs2))) begin
				dispatch = 1'b1;
				dispatch_op = op;
				dispatch_pc = pc;
				dispatch_imm = imm;
				dispatch_rd = rd;
				dispatch_rs1 = rs1;
				dispatch_rs2 = rs2;
				exp_val[rd] = expected_result(op, pc, imm, shadow_value(rs1), shadow_value(rs2));
				pend[rd] = 1'b1;
				pend_rs1[rd] = rs1;
				pend_rs2[rd] = rs2;
				use_cnt[rd]++;
				use_cnt[rs1]++;
				use_cnt[rs2]++;
				n_pending++;
				n_sent++;
				sent++;
			end
		end
		@(negedge CLK);
		dispatch = 1'b0;
	endtask

	task automatic flush_pipeline();
		@(negedge CLK);
		while (full) begin
			@(negedge CLK);
		end
		// lui to the top register, ready at once but flushed before it can issue
		dispatch = 1'b1;
		dispatch_op = OP_LUI;
		dispatch_pc = '0;
		dispatch_imm = 64'hffff_ffff_8765_4000;
		dispatch_rd = RW'(`ADDER_NREG - 1);
		dispatch_rs1 = '0;
		dispatch_rs2 = '0;
		@(negedge CLK);
		dispatch = 1'b0;
		flush = 1'b1;
		@(negedge CLK);
		flush = 1'b0;
		// a result already in execute retires within two edges
		repeat (2) @(negedge CLK);
		// the extra one is the lui above
		n_flushed += n_pending + 1;
		for (int r = 0; r < `ADDER_NREG; r++) begin
			pend[r] = 1'b0;
			use_cnt[r] = 0;
		end
		n_pending = 0;
	endtask

	always @(posedge CLK) begin
		if (!reset && wb_valid === 1'b1) begin
			assert (pend[wb_rd]) else begin
				$display("unexpected writeback to x%0d at %0t, nothing pending for it",
					wb_rd, $time);
				other_errors++;
			end
			if (pend[wb_rd]) begin
				n_checked++;
				assert (wb_data === exp_val[wb_rd]) else begin
					$display("** Error at %0t: x%0d written with %h, expected %h",
						$time, wb_rd, wb_data, exp_val[wb_rd]);
					value_errors++;
				end
				if (wb_rd != '0) begin
					committed[wb_rd] = exp_val[wb_rd];
				end
				use_cnt[wb_rd]--;
				use_cnt[pend_rs1[wb_rd]]--;
				use_cnt[pend_rs2[wb_rd]]--;
				pend[wb_rd] = 1'b0;
				n_pending--;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("watchdog expired after %0d cycles, %0d writebacks missing",
			WATCHDOG_CYCLES, n_pending);
		$display("Test failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h34ae_545d));
		reset = 1'b1;
		flush = 1'b0;
		dispatch = 1'b0;
		dispatch_op = OP_ADD;
		dispatch_pc = '0;
		dispatch_imm = '0;
		dispatch_rd = '0;
		dispatch_rs1 = '0;
		dispatch_rs2 = '0;
		for (int r = 0; r < `ADDER_NREG; r++) begin
			committed[r] = '0;
			exp_val[r] = '0;
			pend[r] = 1'b0;
			use_cnt[r] = 0;
		end
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		send_batch(N_BEFORE);
		flush_pipeline();
		send_batch(N_AFTER);
		while (n_pending != 0) begin
			@(negedge CLK);
		end
		repeat (4) @(negedge CLK);
		$display("sent %0d, checked %0d, flushed %0d, value errors %0d, other errors %0d, %s %0d",
			n_sent, n_checked, n_flushed, value_errors, other_errors,
			"assertion failures", i_dut.i_asserts.assert_fails);
		if (value_errors == 0 && other_errors == 0 && i_dut.i_asserts.assert_fails == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
